// File: design/core_pkg.sv
////////////////////////////////////////
// Core architecture definitions
// Register index, opcodes and the
// instruction word field layout
////////////////////////////////////////
`default_nettype none

package core_pkg;

    localparam int XLEN_DEFAULT = 32;    // Default datapath width
    localparam int REG_IDX_W    = 5;     // 32 architectural registers
    localparam int LANES        = 2;     // Issue width

    localparam logic [REG_IDX_W-1:0] ZERO_REG = '0;  // Hardwired zero

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    localparam logic [3:0] OP_NOP  = 4'h0;
    localparam logic [3:0] OP_ADD  = 4'h1;
    localparam logic [3:0] OP_SUB  = 4'h2;
    localparam logic [3:0] OP_AND  = 4'h3;
    localparam logic [3:0] OP_OR   = 4'h4;
    localparam logic [3:0] OP_XOR  = 4'h5;
    localparam logic [3:0] OP_ADDI = 4'h6;

    ////////////////////////////////////////
    // Field positions, low bit first
    ////////////////////////////////////////
    localparam int OP_LSB  = 0;          // 4-bit opcode
    localparam int OP_W    = 4;
    localparam int RD_LSB  = 4;
    localparam int RS1_LSB = 9;
    localparam int RS2_LSB = 14;
    localparam int IMM_LSB = 19;         // Signed immediate in the top bits
    localparam int IMM_W   = 13;

endpackage

`default_nettype wire

// File: design/apb_pkg.sv
////////////////////////////////////////
// Host bus address map
// Word offsets of the APB slave
////////////////////////////////////////
`default_nettype none

package apb_pkg;

    localparam int ADDR_W = 12;

    localparam logic [ADDR_W-1:0] ADDR_INSN0   = 12'h000;  // Lane 0 instruction, R/W
    localparam logic [ADDR_W-1:0] ADDR_INSN1   = 12'h004;  // Lane 1 instruction, R/W
    localparam logic [ADDR_W-1:0] ADDR_ISSUE   = 12'h008;  // WO, bits 1:0 lane valids
    localparam logic [ADDR_W-1:0] ADDR_CLEAR   = 12'h00C;  // WO, counter clear
    localparam logic [ADDR_W-1:0] ADDR_RETIRED = 12'h010;  // RO
    localparam logic [ADDR_W-1:0] ADDR_BUNDLES = 12'h014;  // RO

    // Register window, reg n at base + 4n
    localparam logic [ADDR_W-1:0] ADDR_REG_BASE = 12'h080;

endpackage

`default_nettype wire

// File: design/regfile.sv
////////////////////////////////////////
// Dual-lane register file
// Two writes, four reads, with
// write-to-read forwarding
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module regfile #(
    parameter int XLEN = 32
) (
    input  wire                                                clock,
    input  wire [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] read_idx_1,
    input  wire [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] read_idx_2,
    input  wire [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] write_idx,
    input  wire [core_pkg::LANES-1:0]                          write_en,
    input  wire [core_pkg::LANES-1:0][XLEN-1:0]                write_data,
    output logic [core_pkg::LANES-1:0][XLEN-1:0]               read_out_1,
    output logic [core_pkg::LANES-1:0][XLEN-1:0]               read_out_2
);

    localparam int TOP_REG = (1 << core_pkg::REG_IDX_W) - 1;

    logic [XLEN-1:0] mem [1:TOP_REG];    // No storage for reg 0

    // One read port: zero reg, then lane 1, then lane 0, then storage
    function automatic logic [XLEN-1:0] read_port(
        input logic [core_pkg::REG_IDX_W-1:0] idx
    );
        if (idx == core_pkg::ZERO_REG)
            return '0;
        else if (write_en[1] && write_idx[1] == idx)
            return write_data[1];        // Lane 1 is youngest
        else if (write_en[0] && write_idx[0] == idx)
            return write_data[0];
        else
            return mem[idx];
    endfunction

    always_comb begin
        for (int i = 0; i < core_pkg::LANES; i++) begin
            read_out_1[i] = read_port(read_idx_1[i]);
            read_out_2[i] = read_port(read_idx_2[i]);   // Own index per port
        end
    end

    ////////////////////////////////////////
    // Write ports, lane 1 wins a collision
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (write_en[1] && write_idx[1] != core_pkg::ZERO_REG)
            mem[write_idx[1]] <= write_data[1];
        if (write_en[0] && write_idx[0] != core_pkg::ZERO_REG &&
            !(write_en[1] && write_idx[1] == write_idx[0]))
            mem[write_idx[0]] <= write_data[0];
    end

endmodule

`default_nettype wire

// File: design/alu_lane.sv
////////////////////////////////////////
// Single lane decode and ALU
// Combinational result and rd enable
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module alu_lane #(
    parameter int XLEN = 32
) (
    input  wire [31:0]     insn,
    input  wire [XLEN-1:0] op_a,
    input  wire [XLEN-1:0] op_b,
    output logic [XLEN-1:0] result,
    output logic            writes_rd
);

    logic [core_pkg::OP_W-1:0]      opcode;
    logic [core_pkg::REG_IDX_W-1:0] rd;
    logic [core_pkg::IMM_W-1:0]     imm;
    logic [XLEN-1:0]                imm_ext;
    logic                           op_known;

    assign opcode  = insn[core_pkg::OP_LSB +: core_pkg::OP_W];
    assign rd      = insn[core_pkg::RD_LSB +: core_pkg::REG_IDX_W];
    assign imm     = insn[core_pkg::IMM_LSB +: core_pkg::IMM_W];
    assign imm_ext = {{(XLEN-core_pkg::IMM_W){imm[core_pkg::IMM_W-1]}}, imm};  // Sign extend

    always_comb begin
        op_known = 1'b1;
        case (opcode)
            core_pkg::OP_ADD:  result = op_a + op_b;
            core_pkg::OP_SUB:  result = op_a - op_b;
            core_pkg::OP_AND:  result = op_a & op_b;
            core_pkg::OP_OR:   result = op_a | op_b;
            core_pkg::OP_XOR:  result = op_a ^ op_b;
            core_pkg::OP_ADDI: result = op_a + imm_ext;
            default: begin                          // NOP and undefined codes
                result   = '0;
                op_known = 1'b0;
            end
        endcase
    end

    // Nothing to write for NOP, bad opcode or r0
    assign writes_rd = op_known && (rd != core_pkg::ZERO_REG);

endmodule

`default_nettype wire

// File: design/issue_pipe.sv
////////////////////////////////////////
// Two-stage issue pipeline
// Decode/read in the issue cycle,
// register file writeback one later
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module issue_pipe #(
    parameter int XLEN = 32
) (
    input  wire                                                 clock,
    input  wire                                                 arst_n,
    input  wire                                                 issue_valid,
    input  wire [1:0]                                           lane_valid,
    input  wire [31:0]                                          insn0,
    input  wire [31:0]                                          insn1,
    input  wire [core_pkg::REG_IDX_W-1:0]                       dbg_read_idx,
    input  wire [core_pkg::LANES-1:0][XLEN-1:0]                 rf_read_1,
    input  wire [core_pkg::LANES-1:0][XLEN-1:0]                 rf_read_2,
    output logic [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] rf_read_idx_1,
    output logic [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] rf_read_idx_2,
    output logic [core_pkg::LANES-1:0][core_pkg::REG_IDX_W-1:0] rf_write_idx,
    output logic [core_pkg::LANES-1:0]                          rf_write_en,
    output logic [core_pkg::LANES-1:0][XLEN-1:0]                rf_write_data,
    output logic [XLEN-1:0]                                     dbg_read_data,
    output logic                                                retire,
    output logic [1:0]                                          retire_count
);

    logic [core_pkg::LANES-1:0][31:0]     insn;
    logic [core_pkg::LANES-1:0][XLEN-1:0] result;
    logic [core_pkg::LANES-1:0]           writes_rd;

    assign insn = {insn1, insn0};

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < core_pkg::LANES; i++) begin
            rf_read_idx_1[i] = insn[i][core_pkg::RS1_LSB +: core_pkg::REG_IDX_W];
            rf_read_idx_2[i] = insn[i][core_pkg::RS2_LSB +: core_pkg::REG_IDX_W];
        end
        if (!issue_valid)
            rf_read_idx_1[0] = dbg_read_idx;     // Host borrows the idle port
    end

    assign dbg_read_data = rf_read_1[0];

    for (genvar g = 0; g < core_pkg::LANES; g++) begin : g_lane
        alu_lane #(.XLEN(XLEN)) i_alu (
            .insn      (insn[g]),
            .op_a      (rf_read_1[g]),
            .op_b      (rf_read_2[g]),
            .result    (result[g]),
            .writes_rd (writes_rd[g])
        );
    end

    ////////////////////////////////////////
    // Writeback stage
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rf_write_en <= '0;
            retire      <= 1'b0;
        end else begin
            rf_write_en <= {core_pkg::LANES{issue_valid}} & lane_valid & writes_rd;
            retire      <= issue_valid && (|lane_valid);   // One-cycle pulse
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            for (int i = 0; i < core_pkg::LANES; i++)
                rf_write_idx[i] <= insn[i][core_pkg::RD_LSB +: core_pkg::REG_IDX_W];
            rf_write_data <= result;
            retire_count  <= {1'b0, lane_valid[0]} + {1'b0, lane_valid[1]};  // Valid lanes
        end
    end

endmodule

`default_nettype wire

// File: design/host_fsm.sv
////////////////////////////////////////
// APB slave control
// Instruction registers, bundle issue,
// register and counter readback
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module host_fsm #(
    parameter int XLEN    = 32,
    parameter int COUNT_W = 32
) (
    input  wire                            clock,
    input  wire                            arst_n,
    input  wire [apb_pkg::ADDR_W-1:0]      paddr,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire [31:0]                     pwdata,
    input  wire [XLEN-1:0]                 dbg_read_data,
    input  wire [COUNT_W-1:0]              retired_count,
    input  wire [COUNT_W-1:0]              bundle_count,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           issue_valid,
    output logic [1:0]                     lane_valid,
    output logic [31:0]                    insn0,
    output logic [31:0]                    insn1,
    output logic [core_pkg::REG_IDX_W-1:0] dbg_read_idx,
    output logic                           clear
);

    localparam int AW      = apb_pkg::ADDR_W;
    localparam int WIN_LSB = core_pkg::REG_IDX_W + 2;   // Register window size bit

    typedef enum logic [1:0] {IDLE, ACT, RESPOND} state_t;

    state_t state;
    logic   act;
    logic   hit_insn0, hit_insn1, hit_issue, hit_clear;
    logic   hit_retired, hit_bundles, hit_reg;
    logic   wr_ok, rd_ok, bad;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign act         = (state == ACT);               // First access cycle
    assign hit_insn0   = (paddr == apb_pkg::ADDR_INSN0);
    assign hit_insn1   = (paddr == apb_pkg::ADDR_INSN1);
    assign hit_issue   = (paddr == apb_pkg::ADDR_ISSUE);
    assign hit_clear   = (paddr == apb_pkg::ADDR_CLEAR);
    assign hit_retired = (paddr == apb_pkg::ADDR_RETIRED);
    assign hit_bundles = (paddr == apb_pkg::ADDR_BUNDLES);
    assign hit_reg     = (paddr[AW-1:WIN_LSB] == apb_pkg::ADDR_REG_BASE[AW-1:WIN_LSB]) &&
                         (paddr[1:0] == 2'b00);        // Word aligned only

    assign wr_ok = hit_insn0 | hit_insn1 | hit_issue | hit_clear;
    assign rd_ok = hit_insn0 | hit_insn1 | hit_retired | hit_bundles | hit_reg;
    assign bad   = pwrite ? !wr_ok : !rd_ok;           // Unmapped or wrong direction

    // Side effects only in the act cycle
    assign lane_valid   = pwdata[1:0];
    assign issue_valid  = act && pwrite && hit_issue && (|pwdata[1:0]);
    assign clear        = act && pwrite && hit_clear;
    assign dbg_read_idx = paddr[WIN_LSB-1:2];

    ////////////////////////////////////////
    // Transfer sequencing
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (psel && !penable)
                        state <= ACT;               // Setup phase seen
                end
                ACT: begin
                    state   <= RESPOND;
                    pready  <= 1'b1;
                    pslverr <= bad;
                end
                default: begin                      // RESPOND, transfer done
                    state   <= IDLE;
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                end
            endcase
        end
    end

    // Instruction words and read data
    always_ff @(posedge clock) begin
        if (act) begin
            if (pwrite) begin
                if (hit_insn0)
                    insn0 <= pwdata;
                if (hit_insn1)
                    insn1 <= pwdata;
            end else begin
                if (hit_insn0)
                    prdata <= insn0;
                else if (hit_insn1)
                    prdata <= insn1;
                else if (hit_retired)
                    prdata <= 32'(retired_count);
                else if (hit_bundles)
                    prdata <= 32'(bundle_count);
                else if (hit_reg)
                    prdata <= 32'(dbg_read_data);   // Low word for wide XLEN
                else
                    prdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/perf_counter.sv
////////////////////////////////////////
// Performance counters
// Retired instructions and bundles
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module perf_counter #(
    parameter int COUNT_W = 32
) (
    input  wire               clock,
    input  wire               arst_n,
    input  wire               retire,
    input  wire [1:0]         retire_count,
    input  wire               issue_valid,
    input  wire               clear,
    output logic [COUNT_W-1:0] retired_count,
    output logic [COUNT_W-1:0] bundle_count
);

    logic bundle_pend;   // Issue delayed to its writeback cycle

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bundle_pend   <= 1'b0;
            retired_count <= '0;
            bundle_count  <= '0;
        end else begin
            bundle_pend <= issue_valid;
            if (clear) begin                        // Clear beats increments
                retired_count <= '0;
                bundle_count  <= '0;
            end else begin
                if (retire)
                    retired_count <= retired_count + COUNT_W'(retire_count);
                if (bundle_pend)
                    bundle_count <= bundle_count + 1'b1;   // Wraps
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dual_issue_top.sv
////////////////////////////////////////
// Dual-issue datapath top level
// APB host port, issue pipeline,
// register file and counters
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dual_issue_top #(
    parameter int XLEN    = core_pkg::XLEN_DEFAULT,
    parameter int COUNT_W = 32
) (
    input  wire                       clock,
    input  wire                       arst_n,
    input  wire [apb_pkg::ADDR_W-1:0] paddr,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [31:0]                pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    localparam int L  = core_pkg::LANES;
    localparam int RW = core_pkg::REG_IDX_W;

    // Host to pipeline
    logic                issue_valid;
    logic [1:0]          lane_valid;
    logic [31:0]         insn0, insn1;
    logic [RW-1:0]       dbg_read_idx;
    logic [XLEN-1:0]     dbg_read_data;
    logic                clear;

    // Pipeline to register file
    logic [L-1:0][RW-1:0]   rf_read_idx_1, rf_read_idx_2, rf_write_idx;
    logic [L-1:0]           rf_write_en;
    logic [L-1:0][XLEN-1:0] rf_write_data, rf_read_1, rf_read_2;

    // Counters
    logic                retire;
    logic [1:0]          retire_count;
    logic [COUNT_W-1:0]  retired_count, bundle_count;

    host_fsm #(.XLEN(XLEN), .COUNT_W(COUNT_W)) i_host_fsm (
        .clock, .arst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .dbg_read_data, .retired_count, .bundle_count,
        .prdata, .pready, .pslverr,
        .issue_valid, .lane_valid, .insn0, .insn1,
        .dbg_read_idx, .clear
    );

    issue_pipe #(.XLEN(XLEN)) i_issue_pipe (
        .clock, .arst_n,
        .issue_valid, .lane_valid, .insn0, .insn1, .dbg_read_idx,
        .rf_read_1, .rf_read_2,
        .rf_read_idx_1, .rf_read_idx_2,
        .rf_write_idx, .rf_write_en, .rf_write_data,
        .dbg_read_data, .retire, .retire_count
    );

    regfile #(.XLEN(XLEN)) i_regfile (
        .clock,
        .read_idx_1 (rf_read_idx_1),
        .read_idx_2 (rf_read_idx_2),
        .write_idx  (rf_write_idx),
        .write_en   (rf_write_en),
        .write_data (rf_write_data),
        .read_out_1 (rf_read_1),
        .read_out_2 (rf_read_2)
    );

    perf_counter #(.COUNT_W(COUNT_W)) i_perf_counter (
        .clock, .arst_n,
        .retire, .retire_count, .issue_valid, .clear,
        .retired_count, .bundle_count
    );

endmodule

`default_nettype wire

// File: bench/dual_issue_tb.sv
////////////////////////////////////////
// Dual-issue datapath testbench
// Random bundles over APB, checked
// against a register and counter model
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dual_issue_tb;

    localparam int NUM_BUNDLES = 40;
    // Init, random bundles with sweeps, directed and error tests
    localparam int XFERS    = 16 * 3 + 32 + NUM_BUNDLES * 35 + 160;
    localparam int WD_CYCLES = XFERS * 8 + 8;

    logic        clock;
    logic        arst_n;
    logic [11:0] paddr;
    logic        psel, penable, pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready, pslverr;

    int          seed = 32'h0b3c67ae;
    int          errors = 0;
    logic [31:0] model_reg [0:31];                 // Architectural state
    logic [31:0] model_retired, model_bundles;

    dual_issue_top #(.XLEN(32), .COUNT_W(32)) i_dut (
        .clock, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////
    // Bus access
    ////////////////////////////////////////
    task automatic apb_xfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clock);
        #1;
        paddr   = addr;                            // Setup phase
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #1;
        penable = 1'b1;
        if (pready !== 1'b0) begin                 // First access cycle
            errors++;
            $display("mismatch pready at %h: got %h expected 0", addr, pready);
        end
        waits = 0;
        do begin
            @(posedge clock);
            #1;
            waits++;
        end while (pready !== 1'b1);
        if (waits != 1) begin
            errors++;
            $display("pready at %h came %0d access cycles late", addr, waits - 1);
        end
        rdata = prdata;                            // Registered, stable here
        err   = pslverr;
        @(posedge clock);                          // Completion edge
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        if (err !== 1'b0) begin
            errors++;
            $display("mismatch pslverr on write %h: got %h expected 0", addr, err);
        end
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        if (err !== 1'b0) begin
            errors++;
            $display("mismatch pslverr on read %h: got %h expected 0", addr, err);
        end
    endtask

    // Bad address or direction must flag pslverr
    task automatic expect_error(input logic write, input logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_xfer(write, addr, 32'hffff_ffff, rd, err);
        if (err !== 1'b1) begin
            errors++;
            $display("mismatch pslverr at %h (write %0d): got %h expected 1",
                     addr, write, err);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input logic [4:0] idx);
        logic [31:0] rd;
        bus_read(apb_pkg::ADDR_REG_BASE + {idx, 2'b00}, rd);
        check_value($sformatf("prdata r%0d", idx), rd, model_reg[idx]);
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 32; i++)
            check_reg(5'(i));
    endtask

    task automatic check_counters();
        logic [31:0] rd;
        bus_read(apb_pkg::ADDR_RETIRED, rd);
        check_value("prdata retired", rd, model_retired);
        bus_read(apb_pkg::ADDR_BUNDLES, rd);
        check_value("prdata bundles", rd, model_bundles);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic [31:0] encode(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] imm);
        return {imm, rs2, rs1, rd, op};            // Immediate on top, opcode low
    endfunction

    function automatic logic [31:0] alu_model(input logic [31:0] insn,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm;
        imm = {{19{insn[31]}}, insn[31:19]};
        case (insn[3:0])
            core_pkg::OP_ADD:  return a + b;
            core_pkg::OP_SUB:  return a - b;
            core_pkg::OP_AND:  return a & b;
            core_pkg::OP_OR:   return a | b;
            core_pkg::OP_XOR:  return a ^ b;
            core_pkg::OP_ADDI: return a + imm;
            default:           return 32'h0;
        endcase
    endfunction

    function automatic bit writes_reg(input logic [31:0] insn);
        return (insn[3:0] >= 4'd1) && (insn[3:0] <= 4'd6) && (insn[8:4] != 5'd0);
    endfunction

    // Both lanes read old state, lane 1 written last so it wins
    task automatic apply_model(input logic [31:0] i0, input logic [31:0] i1,
                               input logic [1:0] mask);
        logic [31:0] res0, res1;
        res0 = alu_model(i0, model_reg[i0[13:9]], model_reg[i0[18:14]]);
        res1 = alu_model(i1, model_reg[i1[13:9]], model_reg[i1[18:14]]);
        if (mask[0] && writes_reg(i0))
            model_reg[i0[8:4]] = res0;
        if (mask[1] && writes_reg(i1))
            model_reg[i1[8:4]] = res1;
        if (mask != 2'b00)
            model_bundles++;                       // Empty mask issues nothing
        model_retired += mask[0] + mask[1];
    endtask

    task automatic issue_bundle(input logic [31:0] i0, input logic [31:0] i1,
                                input logic [1:0] mask);
        bus_write(apb_pkg::ADDR_INSN0, i0);
        bus_write(apb_pkg::ADDR_INSN1, i1);
        bus_write(apb_pkg::ADDR_ISSUE, {30'h0, mask});
        apply_model(i0, i1, mask);
    endtask

    function automatic logic [31:0] rand_insn();
        logic [31:0] r;
        r    = $random(seed);
        r[3] = 1'b0;                               // Opcodes 0..7, 7 undefined
        return r;
    endfunction

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        logic [31:0] old_r5;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        model_retired = '0;
        model_bundles = '0;
        for (int i = 0; i < 32; i++)
            model_reg[i] = '0;
        repeat (8) @(posedge clock);
        #1;
        arst_n = 1'b1;

        // Known contents via ADDI from r0
        for (int i = 1; i < 32; i += 2)
            issue_bundle(encode(core_pkg::OP_ADDI, 5'(i), 5'd0, 5'd0, 13'($random(seed))),
                         encode(core_pkg::OP_ADDI, 5'(i + 1), 5'd0, 5'd0,
                                13'($random(seed))),
                         2'b11);
        sweep_regs();

        // Random bundles and masks
        for (int n = 0; n < NUM_BUNDLES; n++) begin
            issue_bundle(rand_insn(), rand_insn(), 2'($random(seed)));
            sweep_regs();
        end
        check_counters();

        // Both lanes target r0
        issue_bundle(encode(core_pkg::OP_ADDI, 5'd0, 5'd1, 5'd0, 13'h5),
                     encode(core_pkg::OP_ADD, 5'd0, 5'd1, 5'd2, 13'h0), 2'b11);
        check_reg(5'd0);

        // Same destination, lane 1 survives
        issue_bundle(encode(core_pkg::OP_ADDI, 5'd7, 5'd0, 5'd0, 13'h011),
                     encode(core_pkg::OP_ADDI, 5'd7, 5'd0, 5'd0, 13'h022), 2'b11);
        bus_read(apb_pkg::ADDR_REG_BASE + 12'(4 * 7), rd);
        check_value("prdata r7", rd, 32'h22);

        // Instruction words read back as written
        bus_read(apb_pkg::ADDR_INSN0, rd);
        check_value("prdata insn0", rd,
                    encode(core_pkg::OP_ADDI, 5'd7, 5'd0, 5'd0, 13'h011));
        bus_read(apb_pkg::ADDR_INSN1, rd);
        check_value("prdata insn1", rd,
                    encode(core_pkg::OP_ADDI, 5'd7, 5'd0, 5'd0, 13'h022));

        // Lane 1 reads r5 while lane 0 writes it
        old_r5 = model_reg[5];
        issue_bundle(encode(core_pkg::OP_ADDI, 5'd5, 5'd0, 5'd0, 13'h123),
                     encode(core_pkg::OP_ADD, 5'd6, 5'd5, 5'd0, 13'h0), 2'b11);
        bus_read(apb_pkg::ADDR_REG_BASE + 12'(4 * 6), rd);
        check_value("prdata r6", rd, old_r5);
        sweep_regs();

        // Counters, clear, then count again
        check_counters();
        bus_write(apb_pkg::ADDR_CLEAR, 32'h1);
        model_retired = '0;
        model_bundles = '0;
        check_counters();
        issue_bundle(rand_insn(), rand_insn(), 2'b10);
        check_counters();

        // Unmapped and wrong-direction accesses
        expect_error(1'b0, 12'h040);
        expect_error(1'b1, 12'h040);
        expect_error(1'b1, apb_pkg::ADDR_RETIRED);
        expect_error(1'b1, apb_pkg::ADDR_BUNDLES);
        expect_error(1'b0, apb_pkg::ADDR_ISSUE);
        expect_error(1'b0, apb_pkg::ADDR_CLEAR);
        expect_error(1'b1, apb_pkg::ADDR_REG_BASE + 12'h8);
        expect_error(1'b0, 12'h082);               // Unaligned in the window
        expect_error(1'b0, 12'hffc);
        sweep_regs();
        check_counters();

        $display("Run complete: %0d errors", errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog, eight cycles per expected transfer
    initial begin
        repeat (WD_CYCLES) @(posedge clock);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dual_issue_top.f
design/core_pkg.sv
design/apb_pkg.sv
design/regfile.sv
design/alu_lane.sv
design/issue_pipe.sv
design/host_fsm.sv
design/perf_counter.sv
design/dual_issue_top.sv
bench/dual_issue_tb.sv
